// ==== logic/sweepAcqPkg.sv ====
package sweepAcqPkg;

    ////////////////////////////////////////
    // Word and threshold widths
    ////////////////////////////////////////
    localparam int DAC_WIDTH        = 10;
    localparam int WORD_WIDTH       = 16;
    localparam int PACKET_CNT_WIDTH = 16;

    // Stream markers
    localparam logic [WORD_WIDTH-1:0] HEADER_WORD = 16'h5341;
    localparam logic [WORD_WIDTH-1:0] TAIL_WORD   = 16'hFF45;
    localparam logic [3:0]            PARAM_TAG   = 4'hD;

    ////////////////////////////////////////
    // Timing and buffer sizes
    ////////////////////////////////////////
    localparam int FRAME_WORDS      = 10;
    localparam int SETTLE_CYCLES    = 32;
    localparam int FIFO_DEPTH       = 64;
    localparam int FIFO_ADDR_WIDTH  = $clog2(FIFO_DEPTH);
    localparam int FRAME_CNT_WIDTH  = $clog2(FRAME_WORDS);
    localparam int SETTLE_CNT_WIDTH = $clog2(SETTLE_CYCLES);

    typedef logic [WORD_WIDTH-1:0] dataWord_t;

    // Sweep controller states
    typedef enum logic [3:0] {
        IDLE,
        HEADER,
        PARAM,
        LOAD,
        WAIT_SETTLE,
        WAIT_FRAME,
        READ_WORD,
        STEP_DONE,
        TAIL,
        FINISH
    } sweepState_t;

endpackage

// ==== logic/acqReadIf.sv ====
`timescale 1ns/1ps

interface acqReadIf;
    logic                   readEn;
    sweepAcqPkg::dataWord_t readData;
    logic                   empty;
    logic                   frameReady;

    // Buffer side of the read path
    modport fifoSide (input readEn, output readData, output empty);

    // Frame boundary detection
    modport counterSide (output frameReady);

    // Consumer of buffered frames
    modport controlSide (output readEn, input readData, input empty, input frameReady);

endinterface

// ==== logic/acqFifo.sv ====
`timescale 1ns/1ps

module acqFifo #(
    parameter type payload_t = sweepAcqPkg::dataWord_t
) (
    input  logic     Clk,
    input  logic     reset_n,
    input  logic     writeEn,
    input  payload_t writeData,
    acqReadIf.fifoSide readPort
);

    payload_t mem [sweepAcqPkg::FIFO_DEPTH];
    payload_t readDataQ;

    logic [sweepAcqPkg::FIFO_ADDR_WIDTH-1:0] wrPtr;
    logic [sweepAcqPkg::FIFO_ADDR_WIDTH-1:0] rdPtr;
    logic [sweepAcqPkg::FIFO_ADDR_WIDTH:0]   count;
    logic full;
    logic doWrite;
    logic doRead;

    assign full    = (count == (sweepAcqPkg::FIFO_ADDR_WIDTH + 1)'(sweepAcqPkg::FIFO_DEPTH));
    assign doWrite = writeEn && !full;
    assign doRead  = readPort.readEn && !readPort.empty;

    assign readPort.empty    = (count == '0);
    assign readPort.readData = readDataQ;

    // Pointers and occupancy
    always_ff @(posedge Clk or negedge reset_n) begin
        if (!reset_n) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (doWrite) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (doRead) begin
                rdPtr <= rdPtr + 1'b1;
            end
            if (doWrite && !doRead) begin
                count <= count + 1'b1;
            end else if (doRead && !doWrite) begin
                count <= count - 1'b1;
            end
        end
    end

    // Storage with one cycle of read latency
    always_ff @(posedge Clk) begin
        if (doWrite) begin
            mem[wrPtr] <= writeData;
        end
        if (doRead) begin
            readDataQ <= mem[rdPtr];
        end
    end

endmodule

// ==== logic/frameCounter.sv ====
`timescale 1ns/1ps

module frameCounter (
    input  logic Clk,
    input  logic reset_n,
    input  logic wordAccepted,
    acqReadIf.counterSide readPort
);

    localparam logic [sweepAcqPkg::FRAME_CNT_WIDTH-1:0] LAST_WORD =
        sweepAcqPkg::FRAME_CNT_WIDTH'(sweepAcqPkg::FRAME_WORDS - 1);

    logic [sweepAcqPkg::FRAME_CNT_WIDTH-1:0] wordCount;
    logic frameReadyQ;

    assign readPort.frameReady = frameReadyQ;

    // Count words modulo the frame length
    always_ff @(posedge Clk or negedge reset_n) begin
        if (!reset_n) begin
            wordCount   <= '0;
            frameReadyQ <= 1'b0;
        end else begin
            frameReadyQ <= 1'b0;
            if (wordAccepted) begin
                if (wordCount == LAST_WORD) begin
                    // Full frame now sits in the FIFO
                    wordCount   <= '0;
                    frameReadyQ <= 1'b1;
                end else begin
                    wordCount <= wordCount + 1'b1;
                end
            end
        end
    end

endmodule

// ==== logic/scLoadSequencer.sv ====
`timescale 1ns/1ps

module scLoadSequencer (
    input  logic Clk,
    input  logic reset_n,
    input  logic loadRequest,
    input  logic configDone,
    output logic loadSc,
    output logic settled
);

    localparam logic [sweepAcqPkg::SETTLE_CNT_WIDTH-1:0] SETTLE_LAST =
        sweepAcqPkg::SETTLE_CNT_WIDTH'(sweepAcqPkg::SETTLE_CYCLES - 1);

    logic armed;
    logic counting;
    logic [sweepAcqPkg::SETTLE_CNT_WIDTH-1:0] settleCount;

    always_ff @(posedge Clk or negedge reset_n) begin
        if (!reset_n) begin
            loadSc      <= 1'b0;
            settled     <= 1'b0;
            armed       <= 1'b0;
            counting    <= 1'b0;
            settleCount <= '0;
        end else begin
            loadSc  <= loadRequest;
            settled <= 1'b0;

            if (loadSc) begin
                // Chip is now loading the new threshold
                armed <= 1'b1;
            end else if (armed && configDone) begin
                armed       <= 1'b0;
                counting    <= 1'b1;
                settleCount <= '0;
            end

            // Front end settle time
            if (counting) begin
                if (settleCount == SETTLE_LAST) begin
                    counting <= 1'b0;
                    settled  <= 1'b1;
                end else begin
                    settleCount <= settleCount + 1'b1;
                end
            end
        end
    end

endmodule

// ==== logic/sweepAcqControl.sv ====
`timescale 1ns/1ps

module sweepAcqControl (
    input  logic                                      Clk,
    input  logic                                      reset_n,
    input  logic                                      sweepStart,
    input  logic [sweepAcqPkg::DAC_WIDTH-1:0]         startDac,
    input  logic [sweepAcqPkg::DAC_WIDTH-1:0]         endDac,
    input  logic [sweepAcqPkg::PACKET_CNT_WIDTH-1:0]  maxPackets,
    input  logic                                      settled,
    output logic                                      loadRequest,
    output logic [sweepAcqPkg::DAC_WIDTH-1:0]         dacOut,
    output logic                                      singleAcqStart,
    output logic                                      oneDacDone,
    output logic                                      acqDone,
    output sweepAcqPkg::dataWord_t                    dataOut,
    output logic                                      dataValid,
    acqReadIf.controlSide                             readPort
);

    localparam logic [sweepAcqPkg::FRAME_CNT_WIDTH-1:0] LAST_WORD =
        sweepAcqPkg::FRAME_CNT_WIDTH'(sweepAcqPkg::FRAME_WORDS - 1);

    sweepAcqPkg::sweepState_t state;

    logic [sweepAcqPkg::DAC_WIDTH-1:0]        threshold;
    logic [sweepAcqPkg::DAC_WIDTH-1:0]        endReg;
    logic [sweepAcqPkg::PACKET_CNT_WIDTH-1:0] maxReg;
    logic [sweepAcqPkg::PACKET_CNT_WIDTH-1:0] framesLeft;
    logic [sweepAcqPkg::PACKET_CNT_WIDTH-1:0] pendingFrames;
    logic [sweepAcqPkg::FRAME_CNT_WIDTH-1:0]  wordCount;
    logic sweepStartQ;
    logic readEnReg;
    logic readValid;
    logic frameStart;

    // Slow control expects the DAC code LSB first
    function automatic logic [sweepAcqPkg::DAC_WIDTH-1:0] bitReverse(
        input logic [sweepAcqPkg::DAC_WIDTH-1:0] value
    );
        logic [sweepAcqPkg::DAC_WIDTH-1:0] result;
        for (int i = 0; i < sweepAcqPkg::DAC_WIDTH; i++) begin
            result[i] = value[sweepAcqPkg::DAC_WIDTH-1-i];
        end
        return result;
    endfunction

    assign readPort.readEn = readEnReg;
    assign frameStart = (state == sweepAcqPkg::WAIT_FRAME) && (framesLeft != '0) &&
                        (pendingFrames != '0) && !readPort.empty;

    ////////////////////////////////////////
    // Frames sitting in the FIFO
    ////////////////////////////////////////
    always_ff @(posedge Clk or negedge reset_n) begin
        if (!reset_n) begin
            pendingFrames <= '0;
        end else begin
            case ({readPort.frameReady, frameStart})
                2'b10:   pendingFrames <= pendingFrames + 1'b1;
                2'b01:   pendingFrames <= pendingFrames - 1'b1;
                default: pendingFrames <= pendingFrames;
            endcase
        end
    end

    ////////////////////////////////////////
    // Sweep FSM
    ////////////////////////////////////////
    always_ff @(posedge Clk or negedge reset_n) begin
        if (!reset_n) begin
            state          <= sweepAcqPkg::IDLE;
            threshold      <= '0;
            endReg         <= '0;
            maxReg         <= '0;
            framesLeft     <= '0;
            wordCount      <= '0;
            sweepStartQ    <= 1'b0;
            readEnReg      <= 1'b0;
            readValid      <= 1'b0;
            loadRequest    <= 1'b0;
            dacOut         <= '0;
            singleAcqStart <= 1'b0;
            oneDacDone     <= 1'b0;
            acqDone        <= 1'b0;
            dataValid      <= 1'b0;
        end else begin
            sweepStartQ <= sweepStart;
            readValid   <= readEnReg;
            loadRequest <= 1'b0;
            oneDacDone  <= 1'b0;
            acqDone     <= 1'b0;
            // FIFO data goes out the cycle after it appears
            dataValid   <= readValid;

            case (state)
                sweepAcqPkg::IDLE: begin
                    if (sweepStart && !sweepStartQ) begin
                        threshold <= startDac;
                        endReg    <= endDac;
                        maxReg    <= maxPackets;
                        state     <= sweepAcqPkg::HEADER;
                    end
                end
                sweepAcqPkg::HEADER: begin
                    dataValid <= 1'b1;
                    state     <= sweepAcqPkg::PARAM;
                end
                sweepAcqPkg::PARAM: begin
                    dataValid <= 1'b1;
                    dacOut    <= bitReverse(threshold);
                    state     <= sweepAcqPkg::LOAD;
                end
                sweepAcqPkg::LOAD: begin
                    loadRequest <= 1'b1;
                    state       <= sweepAcqPkg::WAIT_SETTLE;
                end
                sweepAcqPkg::WAIT_SETTLE: begin
                    if (settled) begin
                        singleAcqStart <= 1'b1;
                        framesLeft     <= maxReg;
                        state          <= sweepAcqPkg::WAIT_FRAME;
                    end
                end
                sweepAcqPkg::WAIT_FRAME: begin
                    if (framesLeft == '0) begin
                        state <= sweepAcqPkg::STEP_DONE;
                    end else if (frameStart) begin
                        readEnReg  <= 1'b1;
                        wordCount  <= '0;
                        framesLeft <= framesLeft - 1'b1;
                        state      <= sweepAcqPkg::READ_WORD;
                    end
                end
                sweepAcqPkg::READ_WORD: begin
                    // One read per cycle until the frame is drained
                    if (wordCount == LAST_WORD) begin
                        readEnReg <= 1'b0;
                        state     <= sweepAcqPkg::WAIT_FRAME;
                    end else begin
                        wordCount <= wordCount + 1'b1;
                    end
                end
                sweepAcqPkg::STEP_DONE: begin
                    singleAcqStart <= 1'b0;
                    oneDacDone     <= 1'b1;
                    if (threshold >= endReg) begin
                        state <= sweepAcqPkg::TAIL;
                    end else begin
                        threshold <= threshold + 1'b1;
                        state     <= sweepAcqPkg::PARAM;
                    end
                end
                sweepAcqPkg::TAIL: begin
                    dataValid <= 1'b1;
                    state     <= sweepAcqPkg::FINISH;
                end
                sweepAcqPkg::FINISH: begin
                    acqDone <= 1'b1;
                    state   <= sweepAcqPkg::IDLE;
                end
                default: state <= sweepAcqPkg::IDLE;
            endcase
        end
    end

    // Output word mux
    always_ff @(posedge Clk) begin
        if (readValid) begin
            dataOut <= readPort.readData;
        end else if (state == sweepAcqPkg::HEADER) begin
            dataOut <= sweepAcqPkg::HEADER_WORD;
        end else if (state == sweepAcqPkg::PARAM) begin
            dataOut <= {sweepAcqPkg::PARAM_TAG, 2'b00, threshold};
        end else if (state == sweepAcqPkg::TAIL) begin
            dataOut <= sweepAcqPkg::TAIL_WORD;
        end
    end

endmodule

// ==== logic/sweepAcqTop.sv ====
`timescale 1ns/1ps

module sweepAcqTop (
    input  logic                                      Clk,
    input  logic                                      reset_n,
    input  logic                                      sweepStart,
    input  logic [sweepAcqPkg::DAC_WIDTH-1:0]         startDac,
    input  logic [sweepAcqPkg::DAC_WIDTH-1:0]         endDac,
    input  logic [sweepAcqPkg::PACKET_CNT_WIDTH-1:0]  maxPackets,
    input  logic                                      configDone,
    input  logic [sweepAcqPkg::WORD_WIDTH-1:0]        parallelData,
    input  logic                                      parallelDataEn,
    output logic [sweepAcqPkg::DAC_WIDTH-1:0]         dacOut,
    output logic                                      loadSc,
    output logic                                      singleAcqStart,
    output logic                                      oneDacDone,
    output logic                                      acqDone,
    output sweepAcqPkg::dataWord_t                    dataOut,
    output logic                                      dataValid
);

    logic wordAccepted;
    logic loadRequest;
    logic settled;

    acqReadIf readBus ();

    // Only words inside an acquisition window are kept
    assign wordAccepted = parallelDataEn && singleAcqStart;

    acqFifo #(
        .payload_t (sweepAcqPkg::dataWord_t)
    ) i_acqFifo (
        .Clk       (Clk),
        .reset_n   (reset_n),
        .writeEn   (wordAccepted),
        .writeData (parallelData),
        .readPort  (readBus.fifoSide)
    );

    frameCounter i_frameCounter (
        .Clk          (Clk),
        .reset_n      (reset_n),
        .wordAccepted (wordAccepted),
        .readPort     (readBus.counterSide)
    );

    scLoadSequencer i_scLoadSequencer (
        .Clk         (Clk),
        .reset_n     (reset_n),
        .loadRequest (loadRequest),
        .configDone  (configDone),
        .loadSc      (loadSc),
        .settled     (settled)
    );

    sweepAcqControl i_sweepAcqControl (
        .Clk            (Clk),
        .reset_n        (reset_n),
        .sweepStart     (sweepStart),
        .startDac       (startDac),
        .endDac         (endDac),
        .maxPackets     (maxPackets),
        .settled        (settled),
        .loadRequest    (loadRequest),
        .dacOut         (dacOut),
        .singleAcqStart (singleAcqStart),
        .oneDacDone     (oneDacDone),
        .acqDone        (acqDone),
        .dataOut        (dataOut),
        .dataValid      (dataValid),
        .readPort       (readBus.controlSide)
    );

endmodule

// ==== verification/sweepAcqChecker.sv ====
`timescale 1ns/1ps

module sweepAcqChecker (
    input logic Clk,
    input logic reset_n,
    input logic firstPulse,
    input logic secondPulse,
    input logic resetQuiet
);

    // Number of failed assertions
    int failCount = 0;

    ////////////////////////////////////////
    // Strobes last exactly one cycle
    ////////////////////////////////////////
    firstPulseWidth: assert property (
        @(posedge Clk) disable iff (!reset_n) firstPulse |=> !firstPulse
    ) else begin
        $error("first control pulse stayed high for more than one cycle");
        failCount++;
    end

    secondPulseWidth: assert property (
        @(posedge Clk) disable iff (!reset_n) secondPulse |=> !secondPulse
    ) else begin
        $error("second control pulse stayed high for more than one cycle");
        failCount++;
    end

    // Outputs held low while reset is asserted
    quietInReset: assert property (
        @(posedge Clk) !reset_n |=> !resetQuiet
    ) else begin
        $error("strobe seen while reset was asserted");
        failCount++;
    end

endmodule

// ==== verification/sweepAcqTb.sv ====
`timescale 1ns/1ps

module sweepAcqTb;

    localparam int NUM_TESTS = 3;

    logic                                     Clk = 1'b0;
    logic                                     reset_n;
    logic                                     sweepStart;
    logic [sweepAcqPkg::DAC_WIDTH-1:0]        startDac;
    logic [sweepAcqPkg::DAC_WIDTH-1:0]        endDac;
    logic [sweepAcqPkg::PACKET_CNT_WIDTH-1:0] maxPackets;
    logic                                     configDone;
    logic [sweepAcqPkg::WORD_WIDTH-1:0]       parallelData;
    logic                                     parallelDataEn;
    logic [sweepAcqPkg::DAC_WIDTH-1:0]        dacOut;
    logic                                     loadSc;
    logic                                     singleAcqStart;
    logic                                     oneDacDone;
    logic                                     acqDone;
    sweepAcqPkg::dataWord_t                   dataOut;
    logic                                     dataValid;

    int seed;
    int errorCount;
    int testsFailed;
    int checkerFails;
    int cycleCount;
    int cycleLimit;
    int curStart;
    int wordTarget;
    int wordsSent;
    int loadsSeen;
    int stepsSeen;
    int donesSeen;
    int waitCycles;
    int totalFrames;
    int sweepFirst [NUM_TESTS];
    int sweepLast [NUM_TESTS];
    int sweepPackets [NUM_TESTS];
    sweepAcqPkg::dataWord_t fedWords [$];
    sweepAcqPkg::dataWord_t outWords [$];

    sweepAcqTop i_sweepAcqTop (
        .Clk            (Clk),
        .reset_n        (reset_n),
        .sweepStart     (sweepStart),
        .startDac       (startDac),
        .endDac         (endDac),
        .maxPackets     (maxPackets),
        .configDone     (configDone),
        .parallelData   (parallelData),
        .parallelDataEn (parallelDataEn),
        .dacOut         (dacOut),
        .loadSc         (loadSc),
        .singleAcqStart (singleAcqStart),
        .oneDacDone     (oneDacDone),
        .acqDone        (acqDone),
        .dataOut        (dataOut),
        .dataValid      (dataValid)
    );

    bind scLoadSequencer sweepAcqChecker i_seqChecker (
        .Clk (Clk), .reset_n (reset_n), .firstPulse (loadSc),
        .secondPulse (settled), .resetQuiet (loadSc)
    );

    bind sweepAcqControl sweepAcqChecker i_ctrlChecker (
        .Clk (Clk), .reset_n (reset_n), .firstPulse (acqDone),
        .secondPulse (oneDacDone), .resetQuiet (dataValid)
    );

    always #4 Clk = ~Clk;

    function automatic int randBelow(input int limit);
        return ($random(seed) & 32'h7FFF_FFFF) % limit;
    endfunction

    // Failed concurrent assertions in both bound checkers
    function automatic int checkerFailures();
        return i_sweepAcqTop.i_scLoadSequencer.i_seqChecker.failCount +
               i_sweepAcqTop.i_sweepAcqControl.i_ctrlChecker.failCount;
    endfunction

    // Chip takes the threshold LSB first
    function automatic logic [sweepAcqPkg::DAC_WIDTH-1:0] mirrorDac(input int value);
        logic [sweepAcqPkg::DAC_WIDTH-1:0] mirrored;
        for (int b = 0; b < sweepAcqPkg::DAC_WIDTH; b++) begin
            mirrored[sweepAcqPkg::DAC_WIDTH-1-b] = value[b];
        end
        return mirrored;
    endfunction

    ////////////////////////////////////////
    // Front end model
    ////////////////////////////////////////
    always @(posedge Clk) begin
        if (reset_n === 1'b1 && loadSc === 1'b1) begin
            assert (dacOut == mirrorDac(curStart + loadsSeen)) else begin
                $display("FAIL %0t: dacOut %h at load %0d, expected %h", $time, dacOut,
                         loadsSeen, mirrorDac(curStart + loadsSeen));
                errorCount++;
            end
            loadsSeen++;
            #1;
            configDone = 1'b0;
            waitCycles = 1 + randBelow(8);
            repeat (waitCycles) @(posedge Clk);
            #1;
            configDone = 1'b1;
        end
    end

    // Bursts of frame words while acquisition is open
    always @(posedge Clk) begin
        #1;
        if (singleAcqStart === 1'b1 && wordsSent < wordTarget) begin
            parallelDataEn = (randBelow(4) != 0);
            parallelData   = $random(seed);
            if (parallelDataEn) begin
                fedWords.push_back(parallelData);
                wordsSent++;
            end
        end else begin
            parallelDataEn = 1'b0;
            if (singleAcqStart !== 1'b1) begin
                wordsSent = 0;
            end
        end
    end

    ////////////////////////////////////////
    // Output monitor
    ////////////////////////////////////////
    always @(posedge Clk) begin
        if (dataValid === 1'b1) begin
            outWords.push_back(dataOut);
        end
        if (oneDacDone === 1'b1) begin
            stepsSeen++;
            assert (singleAcqStart == 1'b0) else begin
                $display("FAIL %0t: singleAcqStart high during oneDacDone", $time);
                errorCount++;
            end
        end
        if (acqDone === 1'b1) begin
            donesSeen++;
            assert (outWords.size() > 0 && outWords[$] == sweepAcqPkg::TAIL_WORD &&
                    !singleAcqStart) else begin
                $display("FAIL %0t: acqDone not preceded by tail word", $time);
                errorCount++;
            end
        end
    end

    always @(posedge Clk) begin
        cycleCount++;
        if (cycleCount >= cycleLimit) begin
            $display("Timeout: sweep did not finish within %0d cycles", cycleLimit);
            $display("Test failed");
            $finish;
        end
    end

    task automatic runSweep(input int idx);
        sweepAcqPkg::dataWord_t expWords [$];
        logic [sweepAcqPkg::DAC_WIDTH-1:0] thCode;
        int errorsBefore;
        int checkerBefore;
        int sweepBad;
        int steps;
        int th;
        int k;
        errorsBefore  = errorCount;
        checkerBefore = checkerFailures();
        steps         = sweepLast[idx] - sweepFirst[idx] + 1;
        @(posedge Clk);
        #1;
        // Control outputs rest low between sweeps, dacOut clear after reset
        assert (!singleAcqStart && !loadSc && !oneDacDone && !acqDone && !dataValid &&
                (idx != 0 || dacOut == '0)) else begin
            $display("FAIL %0t: outputs not idle before sweep %0d", $time, idx);
            errorCount++;
        end
        startDac   = sweepFirst[idx];
        endDac     = sweepLast[idx];
        maxPackets = sweepPackets[idx];
        curStart   = sweepFirst[idx];
        wordTarget = sweepPackets[idx] * sweepAcqPkg::FRAME_WORDS;
        fedWords.delete();
        outWords.delete();
        loadsSeen  = 0;
        stepsSeen  = 0;
        donesSeen  = 0;
        sweepStart = 1'b1;
        repeat (2) @(posedge Clk);
        #1;
        sweepStart = 1'b0;
        while (donesSeen == 0) begin
            @(posedge Clk);
        end
        // Room for any stray words after the done pulse
        repeat (4) @(posedge Clk);

        assert (fedWords.size() == steps * wordTarget) else begin
            $display("FAIL %0t: %0d words fed, expected %0d", $time, fedWords.size(),
                     steps * wordTarget);
            errorCount++;
        end
        expWords.push_back(sweepAcqPkg::HEADER_WORD);
        for (th = sweepFirst[idx]; th <= sweepLast[idx]; th++) begin
            thCode = th;
            expWords.push_back({sweepAcqPkg::PARAM_TAG, 2'b00, thCode});
            for (k = 0; k < wordTarget && fedWords.size() > 0; k++) begin
                expWords.push_back(fedWords.pop_front());
            end
        end
        expWords.push_back(sweepAcqPkg::TAIL_WORD);

        assert (outWords.size() == expWords.size()) else begin
            $display("FAIL %0t: %0d words out, expected %0d", $time, outWords.size(),
                     expWords.size());
            errorCount++;
        end
        for (k = 0; k < outWords.size() && k < expWords.size(); k++) begin
            assert (outWords[k] == expWords[k]) else begin
                $display("FAIL %0t: word %0d is %h, expected %h", $time, k, outWords[k],
                         expWords[k]);
                errorCount++;
            end
        end
        assert (loadsSeen == steps && stepsSeen == steps && donesSeen == 1) else begin
            $display("FAIL %0t: %0d loads, %0d steps, %0d dones for %0d thresholds",
                     $time, loadsSeen, stepsSeen, donesSeen, steps);
            errorCount++;
        end

        sweepBad = (errorCount != errorsBefore) || (checkerFailures() != checkerBefore);
        if (sweepBad) begin
            testsFailed++;
        end
        $display("Sweep %0d (start %0d, end %0d, packets %0d): %s", idx, sweepFirst[idx],
                 sweepLast[idx], sweepPackets[idx], sweepBad ? "FAIL" : "PASS");
    endtask

    initial begin
        seed           = 37;
        errorCount     = 0;
        testsFailed    = 0;
        checkerFails   = 0;
        cycleCount     = 0;
        totalFrames    = 0;
        wordTarget     = 0;
        wordsSent      = 0;
        curStart       = 0;
        reset_n        = 1'b0;
        sweepStart     = 1'b0;
        startDac       = '0;
        endDac         = '0;
        maxPackets     = '0;
        configDone     = 1'b0;
        parallelData   = '0;
        parallelDataEn = 1'b0;

        // Last sweep covers a single threshold
        for (int t = 0; t < NUM_TESTS; t++) begin
            sweepFirst[t]   = randBelow(1000);
            sweepLast[t]    = (t == NUM_TESTS - 1) ? sweepFirst[t] : sweepFirst[t] + randBelow(4);
            sweepPackets[t] = 1 + randBelow(3);
            totalFrames += (sweepLast[t] - sweepFirst[t] + 1) * sweepPackets[t];
        end
        cycleLimit = 2000 + 200 * totalFrames;

        repeat (16) @(posedge Clk);
        #1;
        reset_n = 1'b1;
        repeat (4) @(posedge Clk);

        for (int t = 0; t < NUM_TESTS; t++) begin
            runSweep(t);
        end

        checkerFails = checkerFailures();
        $display("Sweeps run: %0d, failed: %0d, errors: %0d, assertion failures: %0d",
                 NUM_TESTS, testsFailed, errorCount, checkerFails);
        if (errorCount == 0 && checkerFails == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== sim.f ====
logic/sweepAcqPkg.sv
logic/acqReadIf.sv
logic/acqFifo.sv
logic/frameCounter.sv
logic/scLoadSequencer.sv
logic/sweepAcqControl.sv
logic/sweepAcqTop.sv
verification/sweepAcqChecker.sv
verification/sweepAcqTb.sv

// ==== Bender.yml ====
package:
  name: sweep_acq

sources:
  - logic/sweepAcqPkg.sv
  - logic/acqReadIf.sv
  - logic/acqFifo.sv
  - logic/frameCounter.sv
  - logic/scLoadSequencer.sv
  - logic/sweepAcqControl.sv
  - logic/sweepAcqTop.sv
  - target: simulation
    files:
      - verification/sweepAcqChecker.sv
      - verification/sweepAcqTb.sv
